//--- src/fetch_pkg.sv
package fetch_pkg;

  // byte address and program counter
  typedef logic [31:0] addr_t;

  // one 32-bit instruction word
  typedef logic [31:0] inst_t;

  // one read data beat from instruction memory
  typedef logic [63:0] beat_t;

  // performance counter value
  typedef logic [31:0] perf_cnt_t;

  // fetch perf tracking states
  typedef enum logic [1:0] {
    perf_none,
    perf_wait_mem,
    perf_wait_exu
  } perf_state_t;

  // first fetch address after reset
  localparam addr_t RESET_PC = 32'h8000_0000;

  // cycles from AR transfer to rvalid
  localparam int MEM_LATENCY = 3;

  // memory depth in 64-bit beats, 1 KiB total
  localparam int IMEM_BEATS = 128;

  localparam inst_t INST_EBREAK = 32'h0010_0073;

  localparam logic [6:0] OPC_JAL = 7'b110_1111;

endpackage

//--- src/ifu.sv
`timescale 1ns/1ps

module ifu import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  // next fetch address from the execute stand-in
  input  addr_t npc,
  input  logic  halt,
  // AR channel
  input  logic  arready,
  output addr_t araddr,
  output logic  arvalid,
  // R channel
  input  beat_t rdata,
  input  logic  rvalid,
  output logic  rready,
  // decoupled output to decode
  output addr_t pc,
  output inst_t inst,
  output logic  inst_valid,
  input  logic  inst_ready
);

  logic  rstn_q;
  logic  req_q;
  logic  ar_fire;
  logic  r_fire;
  inst_t inst_sel;
  inst_t inst_q;

  // R channel is passed straight through to the decoder handshake
  assign inst_valid = rvalid;
  assign rready     = inst_ready;
  assign r_fire     = rvalid & rready;

  // once halted nothing more goes out on AR
  assign arvalid = req_q & ~halt;
  assign ar_fire = arvalid & arready;

  // bit 2 picks the word inside the 64-bit beat
  assign inst_sel = araddr[2] ? rdata[63:32] : rdata[31:0];
  assign inst     = r_fire ? inst_sel : inst_q;

  // delayed reset, used to launch the first request
  always_ff @(posedge clk) begin
    rstn_q <= rstn;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      req_q  <= 1'b0;
      araddr <= RESET_PC;
      pc     <= RESET_PC;
    end else begin
      if (!rstn_q) begin
        // first cycle out of reset
        req_q <= 1'b1;
      end else if (ar_fire) begin
        req_q <= 1'b0;
        pc    <= araddr;
      end

      // handed downstream, go fetch npc
      if (r_fire) begin
        araddr <= npc;
        req_q  <= 1'b1;
      end
    end
  end

  // last accepted word, shown between fires
  always_ff @(posedge clk) begin
    if (r_fire) begin
      inst_q <= inst_sel;
    end
  end

endmodule

//--- src/imem_axi.sv
`timescale 1ns/1ps

module imem_axi import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  // AR channel
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  // R channel
  output beat_t rdata,
  output logic  rvalid,
  input  logic  rready
);

  // program image as 32-bit words, then packed into beats
  inst_t img [2*IMEM_BEATS];
  beat_t mem [IMEM_BEATS];

  addr_t offset;
  logic [$clog2(IMEM_BEATS)-1:0] beat_idx;

  logic pending;
  logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt;
  logic ar_fire;
  logic r_fire;

  initial begin
    for (int i = 0; i < 2*IMEM_BEATS; i++) begin
      img[i] = '0;
    end
    $readmemh("prog.hex", img);
    // low word sits at the lower address
    for (int i = 0; i < IMEM_BEATS; i++) begin
      mem[i] = {img[2*i+1], img[2*i]};
    end
  end

  // beat index relative to the image base
  assign offset   = araddr - RESET_PC;
  assign beat_idx = offset[3 +: $clog2(IMEM_BEATS)];

  // one read in flight at a time
  assign arready = ~pending;
  assign ar_fire = arvalid & arready;

  // data is ready once the latency count has run out
  assign rvalid = pending & (lat_cnt == '0);
  assign r_fire = rvalid & rready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pending <= 1'b0;
      lat_cnt <= '0;
    end else begin
      if (ar_fire) begin
        pending <= 1'b1;
        lat_cnt <= $bits(lat_cnt)'(MEM_LATENCY - 1);
      end else if (r_fire) begin
        pending <= 1'b0;
      end else if (pending && lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end
    end
  end

  // beat is fetched on the address transfer and held until the R transfer
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata <= mem[beat_idx];
    end
  end

endmodule

//--- src/next_pc.sv
`timescale 1ns/1ps

module next_pc import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  // instruction being handed downstream
  input  addr_t pc,
  input  inst_t inst,
  input  logic  inst_valid,
  input  logic  inst_ready,
  output addr_t npc,
  output logic  halt
);

  addr_t j_imm;
  logic  is_jal;
  logic  fire;

  assign fire   = inst_valid & inst_ready;
  assign is_jal = (inst[6:0] == OPC_JAL);

  // J-type immediate, bit 0 always zero
  assign j_imm = {
    {11{inst[31]}},
    inst[31],
    inst[19:12],
    inst[20],
    inst[30:21],
    1'b0
  };

  always_comb begin
    if (is_jal) begin
      npc = pc + j_imm;
    end else begin
      npc = pc + 32'd4;
    end
  end

  // sticky until the next reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      halt <= 1'b0;
    end else if (fire && inst == INST_EBREAK) begin
      halt <= 1'b1;
    end
  end

endmodule

//--- src/fetch_perf.sv
`timescale 1ns/1ps

module fetch_perf import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      arvalid,
  input  logic      arready,
  input  logic      inst_valid,
  input  logic      inst_ready,
  input  logic      halt,
  output perf_cnt_t fetch_cnt,
  output perf_cnt_t wait_mem_cnt,
  output perf_cnt_t wait_exu_cnt
);

  perf_state_t state;
  logic        ar_fire;
  logic        fire;

  assign ar_fire = arvalid & arready;
  assign fire    = inst_valid & inst_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state        <= perf_none;
      fetch_cnt    <= '0;
      wait_mem_cnt <= '0;
      wait_exu_cnt <= '0;
    end else if (!halt) begin
      case (state)
        perf_wait_mem: begin
          // request issued, beat not yet taken
          wait_mem_cnt <= wait_mem_cnt + 1'b1;
          if (fire) begin
            state <= perf_wait_exu;
          end
        end
        perf_wait_exu: begin
          // waiting for the next address to go out
          wait_exu_cnt <= wait_exu_cnt + 1'b1;
          if (ar_fire) begin
            fetch_cnt <= fetch_cnt + 1'b1;
            state     <= perf_wait_mem;
          end
        end
        default: begin
          if (ar_fire) begin
            fetch_cnt <= fetch_cnt + 1'b1;
            state     <= perf_wait_mem;
          end
        end
      endcase
    end
  end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      idu_ready,
  output addr_t     pc,
  output inst_t     inst,
  output logic      inst_valid,
  output logic      halt,
  output perf_cnt_t fetch_cnt,
  output perf_cnt_t wait_mem_cnt,
  output perf_cnt_t wait_exu_cnt
);

  // AR channel
  addr_t araddr;
  logic  arvalid;
  logic  arready;

  // R channel
  beat_t rdata;
  logic  rvalid;
  logic  rready;

  addr_t npc;

  ifu u_ifu (
    .clk        (clk),
    .rstn       (rstn),
    .npc        (npc),
    .halt       (halt),
    .arready    (arready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rready     (rready),
    .pc         (pc),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (idu_ready)
  );

  imem_axi u_imem (
    .clk     (clk),
    .rstn    (rstn),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  // stands in for execute
  next_pc u_next_pc (
    .clk        (clk),
    .rstn       (rstn),
    .pc         (pc),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (idu_ready),
    .npc        (npc),
    .halt       (halt)
  );

  fetch_perf u_perf (
    .clk          (clk),
    .rstn         (rstn),
    .arvalid      (arvalid),
    .arready      (arready),
    .inst_valid   (inst_valid),
    .inst_ready   (idu_ready),
    .halt         (halt),
    .fetch_cnt    (fetch_cnt),
    .wait_mem_cnt (wait_mem_cnt),
    .wait_exu_cnt (wait_exu_cnt)
  );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

//--- testbench/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

  localparam int T_ORDER = 0;
  localparam int T_BP    = 1;
  localparam int T_HALT  = 2;
  localparam int T_CNT   = 3;
  localparam int T_RESET = 4;

  logic      clk;
  logic      rstn;
  logic      idu_ready;
  addr_t     pc;
  inst_t     inst;
  logic      inst_valid;
  logic      halt;
  perf_cnt_t fetch_cnt;
  perf_cnt_t wait_mem_cnt;
  perf_cnt_t wait_exu_cnt;

  string test_names [5] = '{"fetch_order", "backpressure", "halt", "counters", "reset"};
  int    test_errs [5];
  inst_t img_words [2*IMEM_BEATS];
  int    seed;
  int    walk_len;
  int    wd_limit;
  int    wd_cycles;
  logic  wd_armed;
  int    fire_cnt;
  int    order_tid;
  int    bp_tid;
  int    halt_tid;
  int    n_fail;
  int    n_err;
  addr_t exp_pc;
  inst_t exp_word;
  inst_t last_inst;
  logic  have_prev;
  logic  walk_done;

  tb_clkgen u_clkgen (.clk(clk));

  fetch_top uut (
    .clk          (clk),
    .rstn         (rstn),
    .idu_ready    (idu_ready),
    .pc           (pc),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .halt         (halt),
    .fetch_cnt    (fetch_cnt),
    .wait_mem_cnt (wait_mem_cnt),
    .wait_exu_cnt (wait_exu_cnt)
  );

  function automatic inst_t image_word(input addr_t a);
    int idx;
    idx = int'((a - RESET_PC) >> 2);
    if (idx >= 2*IMEM_BEATS) begin
      return '0;
    end
    return img_words[idx];
  endfunction

  // JAL adds its J immediate and anything else steps by 4
  function automatic addr_t ref_next_pc(input addr_t cur, input inst_t w);
    addr_t imm;
    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    if (w[6:0] == OPC_JAL) begin
      return cur + imm;
    end
    return cur + 32'd4;
  endfunction

  // number of handoffs from the reset pc up to and including EBREAK
  function automatic int ref_walk_length();
    addr_t p;
    int    n;
    p = RESET_PC;
    n = 1;
    while (image_word(p) != INST_EBREAK && n < 2*IMEM_BEATS) begin
      p = ref_next_pc(p, image_word(p));
      n++;
    end
    return n;
  endfunction

  task automatic check_addr(input int tid, string what, addr_t exp, addr_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_names[tid], what, exp, act);
      test_errs[tid]++;
    end
  endtask

  task automatic check_inst(input int tid, string what, inst_t exp, inst_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_names[tid], what, exp, act);
      test_errs[tid]++;
    end
  endtask

  task automatic check_cnt(input int tid, string what, perf_cnt_t exp, perf_cnt_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %0d, actual %0d", test_names[tid], what, exp, act);
      test_errs[tid]++;
    end
  endtask

  task automatic check_bit(input int tid, string what, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %b, actual %b", test_names[tid], what, exp, act);
      test_errs[tid]++;
    end
  endtask

  task automatic check_counters(input int tid);
    check_cnt(tid, "fetch_cnt", perf_cnt_t'(walk_len), fetch_cnt);
    // memory is idle again one cycle after each handoff
    check_cnt(tid, "wait_exu_cnt", perf_cnt_t'(walk_len - 1), wait_exu_cnt);
    if (wait_mem_cnt < perf_cnt_t'(MEM_LATENCY * walk_len)) begin
      $display("Failure in %s: wait_mem_cnt %0d is below the minimum of %0d",
               test_names[tid], wait_mem_cnt, MEM_LATENCY * walk_len);
      test_errs[tid]++;
    end
  endtask

  task automatic report_test(input int tid);
    $display("test %s: %s, %0d errors", test_names[tid],
             test_errs[tid] == 0 ? "pass" : "FAIL", test_errs[tid]);
  endtask

  // two reset cycles with the state checked after the first reset edge
  task automatic apply_reset();
    rstn = 1'b0;
    @(posedge clk);
    @(negedge clk);
    #1;
    check_cnt(T_RESET, "fetch_cnt in reset", '0, fetch_cnt);
    check_cnt(T_RESET, "wait_mem_cnt in reset", '0, wait_mem_cnt);
    check_cnt(T_RESET, "wait_exu_cnt in reset", '0, wait_exu_cnt);
    check_bit(T_RESET, "halt in reset", 1'b0, halt);
    check_bit(T_RESET, "inst_valid in reset", 1'b0, inst_valid);
    check_addr(T_RESET, "pc in reset", RESET_PC, pc);
    exp_pc    = RESET_PC;
    fire_cnt  = 0;
    have_prev = 1'b0;
    walk_done = 1'b0;
    @(posedge clk);
    #10;
    rstn = 1'b1;
  endtask

  // fires == 0 waits for halt and any other value for that many handoffs
  task automatic wait_until(input int fires);
    logic reached;
    reached   = 1'b0;
    wd_cycles = 0;
    wd_armed  = 1'b1;
    while (!reached) begin
      @(negedge clk);
      #1;
      reached = (fires == 0) ? (halt === 1'b1) : (fire_cnt >= fires);
    end
    wd_armed = 1'b0;
  endtask

  always @(posedge clk) begin
    #10;
    idu_ready = ($random(seed) % 2) != 0;
  end

  // every handoff against the reference walk and held values while stalled
  always @(negedge clk) begin
    if (rstn === 1'b1) begin
      // halt rises on the edge that takes EBREAK and not before
      check_bit(halt_tid, "halt level", walk_done, halt);
      if (inst_valid === 1'b1) begin
        if (idu_ready && walk_done) begin
          $display("Failure in %s: instruction handed downstream after EBREAK",
                   test_names[halt_tid]);
          test_errs[halt_tid]++;
        end else if (idu_ready) begin
          exp_word = image_word(exp_pc);
          check_addr(order_tid, $sformatf("pc of fire %0d", fire_cnt), exp_pc, pc);
          check_inst(order_tid, $sformatf("inst of fire %0d", fire_cnt), exp_word, inst);
          last_inst = exp_word;
          have_prev = 1'b1;
          if (exp_word == INST_EBREAK) begin
            walk_done = 1'b1;
          end else begin
            exp_pc = ref_next_pc(exp_pc, exp_word);
          end
        end else begin
          check_addr(bp_tid, "pc held while stalled", exp_pc, pc);
          if (have_prev) begin
            check_inst(bp_tid, "inst held while stalled", last_inst, inst);
          end
        end
        if (idu_ready) begin
          fire_cnt++;
        end
      end
    end
  end

  // stops a run that stops making progress
  initial begin
    wd_cycles = 0;
    while (wd_cycles <= wd_limit) begin
      @(posedge clk);
      if (wd_armed) begin
        wd_cycles++;
      end
    end
    $display("Timeout: the DUT made no progress for %0d cycles, %0d fires seen",
             wd_limit, fire_cnt);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed      = 32'hc914_0e65;
    rstn      = 1'b0;
    idu_ready = 1'b0;
    wd_armed  = 1'b0;
    for (int i = 0; i < 2*IMEM_BEATS; i++) begin
      img_words[i] = '0;
    end
    $readmemh("testbench/prog.hex", img_words);
    walk_len  = ref_walk_length();
    wd_limit  = walk_len * (MEM_LATENCY + 8) * 4;
    order_tid = T_ORDER;
    bp_tid    = T_BP;
    halt_tid  = T_HALT;

    // first run from reset to EBREAK
    apply_reset();
    wait_until(0);
    report_test(T_ORDER);
    report_test(T_BP);

    repeat (20) @(negedge clk);
    #1;
    check_bit(T_HALT, "halt 20 cycles later", 1'b1, halt);
    check_cnt(T_HALT, "fires vs reference walk", perf_cnt_t'(walk_len), perf_cnt_t'(fire_cnt));
    report_test(T_HALT);

    check_counters(T_CNT);
    report_test(T_CNT);

    // restart and reset again halfway before a full walk
    order_tid = T_RESET;
    bp_tid    = T_RESET;
    halt_tid  = T_RESET;
    @(posedge clk);
    #10;
    apply_reset();
    wait_until(walk_len / 2);
    @(posedge clk);
    #10;
    apply_reset();
    wait_until(0);
    check_cnt(T_RESET, "fires after mid-run reset", perf_cnt_t'(walk_len),
              perf_cnt_t'(fire_cnt));
    check_counters(T_RESET);
    report_test(T_RESET);

    n_fail = 0;
    n_err  = 0;
    for (int i = 0; i < 5; i++) begin
      n_err += test_errs[i];
      if (test_errs[i] != 0) begin
        n_fail++;
      end
    end
    $display("summary: 5 tests, %0d passed, %0d failed, %0d errors", 5 - n_fail, n_fail, n_err);
    if (n_err == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/prog.hex
// one 32-bit instruction word per line, in hex
// the first line sits at 0x80000000, each next line 4 bytes higher
01000093
01100093
0180006F
01300093
01400093
01500093
01600093
01700093
01800093
0240006F
01A00093
01B00093
01C0006F
01D00093
01E00093
01F00093
02000093
02100093
FE1FF06F
02300093
0280006F
02500093
02600093
02700093
02800093
02900093
02A00093
02B00093
02C00093
02D00093
02E00093
00100073
03000093
03100093
03200093
03300093
03400093

//--- fetch_sub.f
src/fetch_pkg.sv
src/ifu.sv
src/imem_axi.sv
src/next_pc.sv
src/fetch_perf.sv
src/fetch_top.sv
testbench/tb_clkgen.sv
testbench/tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

# the memory model loads its image from the working directory
cp testbench/prog.hex prog.hex

verilator --binary --timing -Wno-fatal \
  --top-module tb_fetch_top \
  -f fetch_sub.f \
  -o sim_fetch_top

./obj_dir/sim_fetch_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run_sim: failures reported, see sim.log"
  exit 1
fi
echo "run_sim: no failures reported"
